// ==== build.f ====
hdl/decodePkg.sv
hdl/fetchDecode.sv
hdl/executeDecode.sv
hdl/memWbDecode.sv
hdl/hazardTiming.sv
hdl/control.sv
sim/control_properties.sv
sim/controlTb.sv

// ==== hdl/control.sv ====
`timescale 1ns/1ps

module control import decodePkg::*; (
	input instrWord_t instr,
	output logic [NpcSelW-1:0] nextPcSel,
	output logic [NpcOpW-1:0] nextPcOp,
	output logic [CmpOpW-1:0] cmpOp,
	output logic [ExtOpW-1:0] extOp,
	output logic [AluSelW-1:0] aluASel,
	output logic [AluSelW-1:0] aluBSel,
	output logic [AluOpW-1:0] aluOp,
	output logic [XaluOpW-1:0] xaluOp,
	output logic memRead,
	output logic memWrite,
	output logic [MemOpW-1:0] loadOp,
	output logic [MemOpW-1:0] storeOp,
	output logic [DestSelW-1:0] destSel,
	output logic [WdSelW-1:0] wdSel,
	output logic regWrite,
	output logic [TimeW-1:0] tNew,
	output logic [TimeW-1:0] tUseRs,
	output logic [TimeW-1:0] tUseRt
);

	// One decoder per consuming pipeline stage
	fetchDecode fetch (
		.instr(instr),
		.nextPcSel(nextPcSel),
		.nextPcOp(nextPcOp),
		.cmpOp(cmpOp)
	);

	executeDecode execute (
		.instr(instr),
		.extOp(extOp),
		.aluASel(aluASel),
		.aluBSel(aluBSel),
		.aluOp(aluOp),
		.xaluOp(xaluOp)
	);

	memWbDecode memWb (
		.instr(instr),
		.memRead(memRead),
		.memWrite(memWrite),
		.loadOp(loadOp),
		.storeOp(storeOp),
		.destSel(destSel),
		.wdSel(wdSel),
		.regWrite(regWrite)
	);

	hazardTiming hazard (
		.instr(instr),
		.tNew(tNew),
		.tUseRs(tUseRs),
		.tUseRt(tUseRt)
	);

endmodule

// ==== hdl/decodePkg.sv ====
package decodePkg;

	//////////////////////////////
	// Instruction fields
	localparam int OpW = 6;
	localparam int FuncW = 6;
	localparam int RegW = 5;
	localparam int ImmW = 16;

	// Control word widths
	localparam int NpcSelW = 2;
	localparam int NpcOpW = 2;
	localparam int CmpOpW = 4;
	localparam int ExtOpW = 2;
	localparam int AluSelW = 2;
	localparam int AluOpW = 4;
	localparam int XaluOpW = 4;
	localparam int MemOpW = 3;
	localparam int DestSelW = 3;
	localparam int WdSelW = 2;
	localparam int TimeW = 2;

	//////////////////////////////
	// Primary opcodes
	localparam logic [OpW-1:0] OpSpecial = 6'h00, OpRegimm = 6'h01, OpJ = 6'h02, OpJal = 6'h03;
	localparam logic [OpW-1:0] OpBeq = 6'h04, OpBne = 6'h05, OpBlez = 6'h06, OpBgtz = 6'h07;
	localparam logic [OpW-1:0] OpAddi = 6'h08, OpAddiu = 6'h09, OpSlti = 6'h0a, OpSltiu = 6'h0b;
	localparam logic [OpW-1:0] OpAndi = 6'h0c, OpOri = 6'h0d, OpXori = 6'h0e, OpLui = 6'h0f;
	localparam logic [OpW-1:0] OpLb = 6'h20, OpLh = 6'h21, OpLw = 6'h23, OpLbu = 6'h24;
	localparam logic [OpW-1:0] OpLhu = 6'h25, OpSb = 6'h28, OpSh = 6'h29, OpSw = 6'h2b;

	// Special function field
	localparam logic [FuncW-1:0] FnSll = 6'h00, FnSrl = 6'h02, FnSra = 6'h03, FnSllv = 6'h04;
	localparam logic [FuncW-1:0] FnSrlv = 6'h06, FnSrav = 6'h07, FnJr = 6'h08, FnJalr = 6'h09;
	localparam logic [FuncW-1:0] FnMfhi = 6'h10, FnMthi = 6'h11, FnMflo = 6'h12, FnMtlo = 6'h13;
	localparam logic [FuncW-1:0] FnMult = 6'h18, FnMultu = 6'h19, FnDiv = 6'h1a, FnDivu = 6'h1b;
	localparam logic [FuncW-1:0] FnAdd = 6'h20, FnAddu = 6'h21, FnSub = 6'h22, FnSubu = 6'h23;
	localparam logic [FuncW-1:0] FnAnd = 6'h24, FnOr = 6'h25, FnXor = 6'h26, FnNor = 6'h27;
	localparam logic [FuncW-1:0] FnSlt = 6'h2a, FnSltu = 6'h2b;

	// Regimm branches, selected by rt
	localparam logic [RegW-1:0] RtBltz = 5'h00, RtBgez = 5'h01, RtBgezal = 5'h11;

	//////////////////////////////
	// Fetch and decode stage codes
	localparam logic [NpcSelW-1:0] NpcSeq = 2'd0, NpcBranch = 2'd1, NpcReg = 2'd2;
	localparam logic [NpcOpW-1:0] NpcOpBranch = 2'd0, NpcOpJump = 2'd1;
	localparam logic [CmpOpW-1:0] CmpEq = 4'd0, CmpGez = 4'd1, CmpGtz = 4'd2;
	localparam logic [CmpOpW-1:0] CmpLez = 4'd3, CmpLtz = 4'd4, CmpNe = 4'd5;

	// Execute stage codes
	localparam logic [ExtOpW-1:0] ExtSign = 2'd0, ExtZero = 2'd1, ExtUpper = 2'd2;
	localparam logic [AluSelW-1:0] ASelRs = 2'd0, ASelShamt = 2'd1, ASelHiLo = 2'd2;
	localparam logic [AluSelW-1:0] BSelRt = 2'd0, BSelImm = 2'd1, BSelLink = 2'd2;
	localparam logic [AluOpW-1:0] AluAdd = 4'd0, AluSub = 4'd1, AluAnd = 4'd2, AluOr = 4'd3;
	localparam logic [AluOpW-1:0] AluSrl = 4'd4, AluSra = 4'd5, AluSll = 4'd6, AluSlt = 4'd7;
	localparam logic [AluOpW-1:0] AluSltu = 4'd8, AluNor = 4'd9, AluXor = 4'd10;
	localparam logic [AluOpW-1:0] AluPassA = 4'd11, AluPassB = 4'd12, AluRotr = 4'd13;
	localparam logic [XaluOpW-1:0] XaluNone = 4'd0, XaluMult = 4'd1, XaluMultu = 4'd2;
	localparam logic [XaluOpW-1:0] XaluMthi = 4'd3, XaluMtlo = 4'd4, XaluMfhi = 4'd5;
	localparam logic [XaluOpW-1:0] XaluMflo = 4'd6, XaluDiv = 4'd7, XaluDivu = 4'd8;

	// Memory and writeback codes
	localparam logic [MemOpW-1:0] LoadWord = 3'd0, LoadByteU = 3'd1, LoadByte = 3'd2;
	localparam logic [MemOpW-1:0] LoadHalfU = 3'd3, LoadHalf = 3'd4;
	localparam logic [MemOpW-1:0] StoreWord = 3'd0, StoreByte = 3'd1, StoreHalf = 3'd2;
	localparam logic [DestSelW-1:0] DestRd = 3'd0, DestRt = 3'd1, DestRa = 3'd3;
	localparam logic [WdSelW-1:0] WdAlu = 2'd0, WdMem = 2'd1;

	// Operand not read at all
	localparam logic [TimeW-1:0] TuseNever = 2'd3;

	//////////////////////////////
	// One instruction word, R and I views
	typedef union packed {
		struct packed {
			logic [OpW-1:0] op;
			logic [RegW-1:0] rs;
			logic [RegW-1:0] rt;
			logic [RegW-1:0] rd;
			logic [RegW-1:0] shamt;
			logic [FuncW-1:0] func;
		} r;
		struct packed {
			logic [OpW-1:0] op;
			logic [RegW-1:0] rs;
			logic [RegW-1:0] rt;
			logic [ImmW-1:0] imm;
		} i;
	} instrWord_t;

endpackage

// ==== hdl/executeDecode.sv ====
`timescale 1ns/1ps

module executeDecode import decodePkg::*; (
	input instrWord_t instr,
	output logic [ExtOpW-1:0] extOp,
	output logic [AluSelW-1:0] aluASel,
	output logic [AluSelW-1:0] aluBSel,
	output logic [AluOpW-1:0] aluOp,
	output logic [XaluOpW-1:0] xaluOp
);

	always_comb begin
		extOp = ExtSign;
		aluASel = ASelRs;
		aluBSel = BSelRt;
		aluOp = AluAdd;
		xaluOp = XaluNone;
		case (instr.r.op)
			OpSpecial: begin
				case (instr.r.func)
					FnAdd, FnAddu: aluOp = AluAdd;
					FnSub, FnSubu: aluOp = AluSub;
					FnSlt: aluOp = AluSlt;
					FnSltu: aluOp = AluSltu;
					FnAnd: aluOp = AluAnd;
					FnOr: aluOp = AluOr;
					FnNor: aluOp = AluNor;
					FnXor: aluOp = AluXor;
					FnSllv: aluOp = AluSll;
					FnSrlv: aluOp = AluSrl;
					FnSrav: aluOp = AluSra;
					// Shift amount comes from the shamt field
					FnSll: begin
						aluASel = ASelShamt;
						aluOp = AluSll;
					end
					FnSrl: begin
						aluASel = ASelShamt;
						aluOp = (instr.r.rs == RegW'(1)) ? AluRotr : AluSrl;
					end
					FnSra: begin
						aluASel = ASelShamt;
						aluOp = AluSra;
					end
					FnJalr: begin
						aluBSel = BSelLink;
						aluOp = AluPassB;
					end
					FnMult: xaluOp = XaluMult;
					FnMultu: xaluOp = XaluMultu;
					FnDiv: xaluOp = XaluDiv;
					FnDivu: xaluOp = XaluDivu;
					FnMthi: xaluOp = XaluMthi;
					FnMtlo: xaluOp = XaluMtlo;
					// HI or LO goes through operand A
					FnMfhi: begin
						aluASel = ASelHiLo;
						aluOp = AluPassA;
						xaluOp = XaluMfhi;
					end
					FnMflo: begin
						aluASel = ASelHiLo;
						aluOp = AluPassA;
						xaluOp = XaluMflo;
					end
					default: ;
				endcase
			end
			OpAddi, OpAddiu, OpLw, OpLb, OpLbu, OpLh, OpLhu, OpSw, OpSb, OpSh: begin
				aluBSel = BSelImm;
			end
			OpSlti, OpSltiu: begin
				aluBSel = BSelImm;
				aluOp = (instr.r.op == OpSlti) ? AluSlt : AluSltu;
			end
			OpAndi, OpOri, OpXori: begin
				extOp = ExtZero;
				aluBSel = BSelImm;
				case (instr.r.op)
					OpAndi: aluOp = AluAnd;
					OpOri: aluOp = AluOr;
					default: aluOp = AluXor;
				endcase
			end
			OpLui: begin
				extOp = ExtUpper;
				aluBSel = BSelImm;
				aluOp = AluPassB;
			end
			// Link address for jal and bgezal
			OpJal: begin
				aluBSel = BSelLink;
				aluOp = AluPassB;
			end
			OpRegimm: begin
				if (instr.r.rt == RtBgezal) begin
					aluBSel = BSelLink;
					aluOp = AluPassB;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== hdl/fetchDecode.sv ====
`timescale 1ns/1ps

module fetchDecode import decodePkg::*; (
	input instrWord_t instr,
	output logic [NpcSelW-1:0] nextPcSel,
	output logic [NpcOpW-1:0] nextPcOp,
	output logic [CmpOpW-1:0] cmpOp
);

	logic isBranch;

	// Conditional branches and their compare code
	always_comb begin
		isBranch = 1'b1;
		cmpOp = CmpEq;
		case (instr.r.op)
			OpBeq: cmpOp = CmpEq;
			OpBne: cmpOp = CmpNe;
			OpBgtz: cmpOp = CmpGtz;
			OpBlez: cmpOp = CmpLez;
			OpRegimm: begin
				case (instr.i.rt)
					RtBltz: cmpOp = CmpLtz;
					RtBgez, RtBgezal: cmpOp = CmpGez;
					default: isBranch = 1'b0;
				endcase
			end
			default: isBranch = 1'b0;
		endcase
	end

	always_comb begin
		nextPcSel = NpcSeq;
		nextPcOp = NpcOpBranch;
		if (isBranch) begin
			nextPcSel = NpcBranch;
		end else if (instr.r.op == OpJ || instr.r.op == OpJal) begin
			nextPcSel = NpcBranch;
			nextPcOp = NpcOpJump;
		end else if (instr.r.op == OpSpecial &&
				(instr.r.func == FnJr || instr.r.func == FnJalr)) begin
			nextPcSel = NpcReg;
		end
	end

endmodule

// ==== hdl/hazardTiming.sv ====
`timescale 1ns/1ps

module hazardTiming import decodePkg::*; (
	input instrWord_t instr,
	output logic [TimeW-1:0] tNew,
	output logic [TimeW-1:0] tUseRs,
	output logic [TimeW-1:0] tUseRt
);

	// Cycles until a result exists, and until each source is needed
	always_comb begin
		tNew = TimeW'(0);
		tUseRs = TuseNever;
		tUseRt = TuseNever;
		case (instr.r.op)
			OpSpecial: begin
				case (instr.r.func)
					FnAdd, FnAddu, FnSub, FnSubu, FnSlt, FnSltu, FnAnd, FnOr,
					FnNor, FnXor, FnSllv, FnSrlv, FnSrav: begin
						tNew = TimeW'(1);
						tUseRs = TimeW'(1);
						tUseRt = TimeW'(1);
					end
					FnSll, FnSrl, FnSra: begin
						tNew = TimeW'(1);
						tUseRt = TimeW'(1);
					end
					FnMult, FnMultu, FnDiv, FnDivu: begin
						tUseRs = TimeW'(1);
						tUseRt = TimeW'(1);
					end
					FnMthi, FnMtlo: tUseRs = TimeW'(1);
					FnMfhi, FnMflo: tNew = TimeW'(1);
					FnJr, FnJalr: tUseRs = TimeW'(0);
					default: ;
				endcase
			end
			OpLw, OpLb, OpLbu, OpLh, OpLhu: begin
				tNew = TimeW'(2);
				tUseRs = TimeW'(1);
			end
			// Store data is needed only in the memory stage
			OpSw: begin
				tUseRs = TimeW'(1);
				tUseRt = TimeW'(2);
			end
			OpSb, OpSh: begin
				tUseRs = TimeW'(1);
				tUseRt = TimeW'(1);
			end
			OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori: begin
				tNew = TimeW'(1);
				tUseRs = TimeW'(1);
			end
			OpLui: tNew = TimeW'(1);
			OpBeq, OpBne: begin
				tUseRs = TimeW'(0);
				tUseRt = TimeW'(0);
			end
			OpBgtz, OpBlez: tUseRs = TimeW'(0);
			OpRegimm: begin
				case (instr.r.rt)
					RtBltz, RtBgez: tUseRs = TimeW'(0);
					RtBgezal: begin
						tNew = TimeW'(1);
						tUseRs = TimeW'(0);
						tUseRt = TimeW'(0);
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// ==== hdl/memWbDecode.sv ====
`timescale 1ns/1ps

module memWbDecode import decodePkg::*; (
	input instrWord_t instr,
	output logic memRead,
	output logic memWrite,
	output logic [MemOpW-1:0] loadOp,
	output logic [MemOpW-1:0] storeOp,
	output logic [DestSelW-1:0] destSel,
	output logic [WdSelW-1:0] wdSel,
	output logic regWrite
);

	//////////////////////////////
	// Load and store widths
	always_comb begin
		loadOp = LoadWord;
		storeOp = StoreWord;
		case (instr.r.op)
			OpLb: loadOp = LoadByte;
			OpLbu: loadOp = LoadByteU;
			OpLh: loadOp = LoadHalf;
			OpLhu: loadOp = LoadHalfU;
			OpSb: storeOp = StoreByte;
			OpSh: storeOp = StoreHalf;
			default: ;
		endcase
	end

	//////////////////////////////
	// Strobes and register writeback
	always_comb begin
		memRead = 1'b0;
		memWrite = 1'b0;
		destSel = DestRd;
		wdSel = WdAlu;
		regWrite = 1'b0;
		case (instr.r.op)
			OpSpecial: begin
				case (instr.r.func)
					FnAdd, FnAddu, FnSub, FnSubu, FnSlt, FnSltu,
					FnAnd, FnOr, FnNor, FnXor, FnSll, FnSrl, FnSra,
					FnSllv, FnSrlv, FnSrav, FnMfhi, FnMflo, FnJalr: regWrite = 1'b1;
					default: ;
				endcase
			end
			OpLw, OpLb, OpLbu, OpLh, OpLhu: begin
				memRead = 1'b1;
				destSel = DestRt;
				wdSel = WdMem;
				regWrite = 1'b1;
			end
			OpSw, OpSb, OpSh: memWrite = 1'b1;
			OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui: begin
				destSel = DestRt;
				regWrite = 1'b1;
			end
			OpJal: begin
				destSel = DestRa;
				regWrite = 1'b1;
			end
			OpRegimm: begin
				if (instr.r.rt == RtBgezal) begin
					destSel = DestRa;
					regWrite = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module controlTb -f build.f -o simControl
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/simControl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
exit 0

// ==== sim/controlTb.sv ====
`timescale 1ns/1ps

module controlTb import decodePkg::*; ();

	localparam int ResetCycles = 8;
	localparam int NumVectors = 252;
	localparam int WatchdogNs = (NumVectors + ResetCycles) * 4 + 400;

	logic clk;
	logic rstN;
	instrWord_t instr;
	logic [NpcSelW-1:0] nextPcSel;
	logic [NpcOpW-1:0] nextPcOp;
	logic [CmpOpW-1:0] cmpOp;
	logic [ExtOpW-1:0] extOp;
	logic [AluSelW-1:0] aluASel;
	logic [AluSelW-1:0] aluBSel;
	logic [AluOpW-1:0] aluOp;
	logic [XaluOpW-1:0] xaluOp;
	logic memRead;
	logic memWrite;
	logic [MemOpW-1:0] loadOp;
	logic [MemOpW-1:0] storeOp;
	logic [DestSelW-1:0] destSel;
	logic [WdSelW-1:0] wdSel;
	logic regWrite;
	logic [TimeW-1:0] tNew;
	logic [TimeW-1:0] tUseRs;
	logic [TimeW-1:0] tUseRt;

	// Expected values for the word under test
	logic [NpcSelW-1:0] expNextPcSel;
	logic [NpcOpW-1:0] expNextPcOp;
	logic [CmpOpW-1:0] expCmpOp;
	logic [ExtOpW-1:0] expExtOp;
	logic [AluSelW-1:0] expAluASel;
	logic [AluSelW-1:0] expAluBSel;
	logic [AluOpW-1:0] expAluOp;
	logic [XaluOpW-1:0] expXaluOp;
	logic expMemRead;
	logic expMemWrite;
	logic [MemOpW-1:0] expLoadOp;
	logic [MemOpW-1:0] expStoreOp;
	logic [DestSelW-1:0] expDestSel;
	logic [WdSelW-1:0] expWdSel;
	logic expRegWrite;
	logic [TimeW-1:0] expTNew;
	logic [TimeW-1:0] expTUseRs;
	logic [TimeW-1:0] expTUseRt;

	integer seed = 72;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors = 0;

	control UUT (.*);

	bind control controlProperties props (
		.clk(controlTb.clk),
		.memRead(memRead),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.nextPcSel(nextPcSel),
		.nextPcOp(nextPcOp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#1 rstN = 1'b1;
	end

	initial begin
		#WatchdogNs;
		$display("Timeout: the directed tests did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	//////////////////////////////
	// Checking helpers

	task automatic checkField(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			testErrors++;
			$display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	// Idle set, also the base for every directed case
	task automatic setIdle();
		expNextPcSel = NpcSeq;
		expNextPcOp = NpcOpBranch;
		expCmpOp = CmpEq;
		expExtOp = ExtSign;
		expAluASel = ASelRs;
		expAluBSel = BSelRt;
		expAluOp = AluAdd;
		expXaluOp = XaluNone;
		expMemRead = 1'b0;
		expMemWrite = 1'b0;
		expLoadOp = LoadWord;
		expStoreOp = StoreWord;
		expDestSel = DestRd;
		expWdSel = WdAlu;
		expRegWrite = 1'b0;
		expTNew = 2'd0;
		expTUseRs = TuseNever;
		expTUseRt = TuseNever;
	endtask

	// Drive 1 ns after the edge, check just before the next one
	task automatic applyWord(input logic [31:0] word);
		@(posedge clk);
		#1 instr = word;
		#2.5;
		checkField("nextPcSel", 8'(nextPcSel), 8'(expNextPcSel));
		checkField("nextPcOp", 8'(nextPcOp), 8'(expNextPcOp));
		checkField("cmpOp", 8'(cmpOp), 8'(expCmpOp));
		checkField("extOp", 8'(extOp), 8'(expExtOp));
		checkField("aluASel", 8'(aluASel), 8'(expAluASel));
		checkField("aluBSel", 8'(aluBSel), 8'(expAluBSel));
		checkField("aluOp", 8'(aluOp), 8'(expAluOp));
		checkField("xaluOp", 8'(xaluOp), 8'(expXaluOp));
		checkField("memRead", 8'(memRead), 8'(expMemRead));
		checkField("memWrite", 8'(memWrite), 8'(expMemWrite));
		checkField("loadOp", 8'(loadOp), 8'(expLoadOp));
		checkField("storeOp", 8'(storeOp), 8'(expStoreOp));
		checkField("destSel", 8'(destSel), 8'(expDestSel));
		checkField("wdSel", 8'(wdSel), 8'(expWdSel));
		checkField("regWrite", 8'(regWrite), 8'(expRegWrite));
		checkField("tNew", 8'(tNew), 8'(expTNew));
		checkField("tUseRs", 8'(tUseRs), 8'(expTUseRs));
		checkField("tUseRt", 8'(tUseRt), 8'(expTUseRt));
	endtask

	task automatic finishTest(input string name);
		$display("%s done, %0d errors", name, testErrors);
		testErrors = 0;
	endtask

	function automatic logic [31:0] rWord(input logic [4:0] rs, input logic [5:0] func);
		return {OpSpecial, rs, 5'd4, 5'd5, 5'd7, func};
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rt);
		return {op, 5'd3, rt, 16'h8421};
	endfunction

	function automatic bit isKnownOp(input logic [5:0] op);
		return op <= OpLui || op inside {OpLb, OpLh, OpLw, OpLbu, OpLhu, OpSb, OpSh, OpSw};
	endfunction

	//////////////////////////////
	// R-type arithmetic and shifts

	task automatic rCase(input logic [4:0] rs, input logic [5:0] func,
			input logic [3:0] alu, input logic [1:0] aSel);
		setIdle();
		expAluASel = aSel;
		expAluOp = alu;
		expDestSel = DestRd;
		expRegWrite = 1'b1;
		expTNew = 2'd1;
		expTUseRs = (aSel == ASelShamt) ? TuseNever : 2'd1;
		expTUseRt = 2'd1;
		applyWord(rWord(rs, func));
	endtask

	task automatic testRType();
		rCase(5'd3, FnAdd, AluAdd, ASelRs);
		rCase(5'd3, FnAddu, AluAdd, ASelRs);
		rCase(5'd3, FnSub, AluSub, ASelRs);
		rCase(5'd3, FnSubu, AluSub, ASelRs);
		rCase(5'd3, FnSlt, AluSlt, ASelRs);
		rCase(5'd3, FnSltu, AluSltu, ASelRs);
		rCase(5'd3, FnAnd, AluAnd, ASelRs);
		rCase(5'd3, FnOr, AluOr, ASelRs);
		rCase(5'd3, FnNor, AluNor, ASelRs);
		rCase(5'd3, FnXor, AluXor, ASelRs);
		rCase(5'd3, FnSllv, AluSll, ASelRs);
		rCase(5'd3, FnSrlv, AluSrl, ASelRs);
		rCase(5'd3, FnSrav, AluSra, ASelRs);
		rCase(5'd0, FnSll, AluSll, ASelShamt);
		rCase(5'd0, FnSrl, AluSrl, ASelShamt);
		// rs of 1 turns srl into rotr
		rCase(5'd1, FnSrl, AluRotr, ASelShamt);
		rCase(5'd0, FnSra, AluSra, ASelShamt);
		finishTest("R-type");
	endtask

	//////////////////////////////
	// Immediates, loads and stores

	task automatic iCase(input logic [5:0] op, input logic [1:0] ext, input logic [3:0] alu);
		setIdle();
		expExtOp = ext;
		expAluBSel = BSelImm;
		expAluOp = alu;
		expDestSel = DestRt;
		expRegWrite = 1'b1;
		expTNew = 2'd1;
		expTUseRs = (op == OpLui) ? TuseNever : 2'd1;
		applyWord(iWord(op, 5'd4));
	endtask

	task automatic testImmediate();
		iCase(OpAddi, ExtSign, AluAdd);
		iCase(OpAddiu, ExtSign, AluAdd);
		iCase(OpSlti, ExtSign, AluSlt);
		iCase(OpSltiu, ExtSign, AluSltu);
		iCase(OpAndi, ExtZero, AluAnd);
		iCase(OpOri, ExtZero, AluOr);
		iCase(OpXori, ExtZero, AluXor);
		iCase(OpLui, ExtUpper, AluPassB);
		finishTest("immediate");
	endtask

	task automatic memCase(input logic [5:0] op, input bit isLoad, input logic [2:0] width);
		setIdle();
		expAluBSel = BSelImm;
		expTUseRs = 2'd1;
		if (isLoad) begin
			expMemRead = 1'b1;
			expLoadOp = width;
			expDestSel = DestRt;
			expWdSel = WdMem;
			expRegWrite = 1'b1;
			expTNew = 2'd2;
		end else begin
			expMemWrite = 1'b1;
			expStoreOp = width;
			expTUseRt = (op == OpSw) ? 2'd2 : 2'd1;
		end
		applyWord(iWord(op, 5'd4));
	endtask

	task automatic testMemory();
		memCase(OpLw, 1'b1, LoadWord);
		memCase(OpLb, 1'b1, LoadByte);
		memCase(OpLbu, 1'b1, LoadByteU);
		memCase(OpLh, 1'b1, LoadHalf);
		memCase(OpLhu, 1'b1, LoadHalfU);
		memCase(OpSw, 1'b0, StoreWord);
		memCase(OpSb, 1'b0, StoreByte);
		memCase(OpSh, 1'b0, StoreHalf);
		finishTest("load/store");
	endtask

	//////////////////////////////
	// Branches and jumps

	task automatic flowExpect(input logic [1:0] sel, input logic [1:0] npcOp,
			input logic [3:0] cmp, input logic [1:0] useRs, input logic [1:0] useRt);
		setIdle();
		expNextPcSel = sel;
		expNextPcOp = npcOp;
		expCmpOp = cmp;
		expTUseRs = useRs;
		expTUseRt = useRt;
	endtask

	task automatic linkExpect(input logic [2:0] dest, input logic [1:0] tNewVal);
		expAluBSel = BSelLink;
		expAluOp = AluPassB;
		expDestSel = dest;
		expRegWrite = 1'b1;
		expTNew = tNewVal;
	endtask

	task automatic testBranchJump();
		flowExpect(NpcBranch, NpcOpBranch, CmpEq, 2'd0, 2'd0);
		applyWord(iWord(OpBeq, 5'd4));
		flowExpect(NpcBranch, NpcOpBranch, CmpNe, 2'd0, 2'd0);
		applyWord(iWord(OpBne, 5'd4));
		flowExpect(NpcBranch, NpcOpBranch, CmpGtz, 2'd0, TuseNever);
		applyWord(iWord(OpBgtz, 5'd0));
		flowExpect(NpcBranch, NpcOpBranch, CmpLez, 2'd0, TuseNever);
		applyWord(iWord(OpBlez, 5'd0));
		flowExpect(NpcBranch, NpcOpBranch, CmpLtz, 2'd0, TuseNever);
		applyWord(iWord(OpRegimm, RtBltz));
		flowExpect(NpcBranch, NpcOpBranch, CmpGez, 2'd0, TuseNever);
		applyWord(iWord(OpRegimm, RtBgez));
		flowExpect(NpcBranch, NpcOpBranch, CmpGez, 2'd0, 2'd0);
		linkExpect(DestRa, 2'd1);
		applyWord(iWord(OpRegimm, RtBgezal));
		flowExpect(NpcBranch, NpcOpJump, CmpEq, TuseNever, TuseNever);
		applyWord(iWord(OpJ, 5'd4));
		flowExpect(NpcBranch, NpcOpJump, CmpEq, TuseNever, TuseNever);
		linkExpect(DestRa, 2'd0);
		applyWord(iWord(OpJal, 5'd4));
		flowExpect(NpcReg, NpcOpBranch, CmpEq, 2'd0, TuseNever);
		applyWord(rWord(5'd31, FnJr));
		flowExpect(NpcReg, NpcOpBranch, CmpEq, 2'd0, TuseNever);
		linkExpect(DestRd, 2'd0);
		applyWord(rWord(5'd31, FnJalr));
		finishTest("branch/jump");
	endtask

	//////////////////////////////
	// Multiply/divide unit

	task automatic xCase(input logic [5:0] func, input logic [3:0] xop,
			input logic [1:0] useRs, input logic [1:0] useRt);
		setIdle();
		expXaluOp = xop;
		expTUseRs = useRs;
		expTUseRt = useRt;
		if (func == FnMfhi || func == FnMflo) begin
			expAluASel = ASelHiLo;
			expAluOp = AluPassA;
			expDestSel = DestRd;
			expRegWrite = 1'b1;
			expTNew = 2'd1;
		end
		applyWord(rWord(5'd3, func));
	endtask

	task automatic testMulDiv();
		xCase(FnMult, XaluMult, 2'd1, 2'd1);
		xCase(FnMultu, XaluMultu, 2'd1, 2'd1);
		xCase(FnDiv, XaluDiv, 2'd1, 2'd1);
		xCase(FnDivu, XaluDivu, 2'd1, 2'd1);
		xCase(FnMthi, XaluMthi, 2'd1, TuseNever);
		xCase(FnMtlo, XaluMtlo, 2'd1, TuseNever);
		xCase(FnMfhi, XaluMfhi, TuseNever, TuseNever);
		xCase(FnMflo, XaluMflo, TuseNever, TuseNever);
		finishTest("mult/div");
	endtask

	task automatic testUndefined();
		logic [31:0] word;
		for (int n = 0; n < 200; n++) begin
			word = $random(seed);
			while (isKnownOp(word[31:26]))
				word = $random(seed);
			setIdle();
			applyWord(word);
		end
		finishTest("undefined opcodes");
	endtask

	initial begin
		instr = '0;
		setIdle();
		wait (rstN === 1'b1);
		testRType();
		testImmediate();
		testMemory();
		testBranchJump();
		testMulDiv();
		testUndefined();
		$display("Checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== sim/control_properties.sv ====
`timescale 1ns/1ps

module controlProperties import decodePkg::*; (
	input logic clk,
	input logic memRead,
	input logic memWrite,
	input logic regWrite,
	input logic [NpcSelW-1:0] nextPcSel,
	input logic [NpcOpW-1:0] nextPcOp
);

	//////////////////////////////
	// Decoder output invariants
	noDoubleAccess: assert property (@(posedge clk) !(memRead && memWrite))
		else $error("memRead and memWrite are high together");

	storeNoWriteback: assert property (@(posedge clk) memWrite |-> !regWrite)
		else $error("store raises regWrite");

	// Jump operation only with a branch target
	jumpNeedsTarget: assert property (@(posedge clk) nextPcOp != '0 |-> nextPcSel == NpcBranch)
		else $error("nonzero nextPcOp without NpcBranch");

endmodule
